//--- list.f
+incdir+verilog
verilog/datapath_pkg.sv
verilog/inst_fifo.sv
verilog/decoder.sv
verilog/issue_ctrl.sv
verilog/regfile.sv
verilog/forward_top.sv
verilog/alu.sv
verilog/datapath.sv
tests/datapath_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module datapath_tb -f list.f -o sim_datapath
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_datapath > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

//--- tests/datapath_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_settings.svh"

module datapath_tb
    import datapath_pkg::*;
();

    localparam int N_INST      = 300;
    localparam int N_CHAIN     = 40;
    localparam int CYCLE_LIMIT = 40 + 4 * N_INST;

    logic  clk;
    logic  reset_i;
    inst_t inst1_i;
    inst_t inst2_i;
    logic  inst_ok1_i;
    logic  inst_ok2_i;
    logic  fetch_stall_o;
    wb_t   wb_master_o;
    wb_t   wb_slave_o;

    logic [31:0] rng;
    word_t       model_regs [`DP_NUM_REGS];
    inst_t       expected [$];
    inst_t       pending [$];
    int          n_writes;
    int          report_count;
    int          cycle_count = 0;

    datapath i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst1_i       (inst1_i),
        .inst2_i       (inst2_i),
        .inst_ok1_i    (inst_ok1_i),
        .inst_ok2_i    (inst_ok2_i),
        .fetch_stall_o (fetch_stall_o),
        .wb_master_o   (wb_master_o),
        .wb_slave_o    (wb_slave_o)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic reg_addr_t rs_of(inst_t inst);
        return inst[`DP_RS_LSB +: $bits(reg_addr_t)];
    endfunction

    function automatic reg_addr_t rt_of(inst_t inst);
        return inst[`DP_RT_LSB +: $bits(reg_addr_t)];
    endfunction

    function automatic logic is_rtype(inst_t inst);
        return inst[`DP_OP_MSB -: 6] == 6'h00;
    endfunction

    function automatic reg_addr_t dest_of(inst_t inst);
        return is_rtype(inst) ? inst[`DP_RD_LSB +: $bits(reg_addr_t)] : rt_of(inst);
    endfunction

    function automatic logic writes_of(inst_t inst);
        logic [5:0] funct;
        logic       known;
        funct = inst[`DP_SHAMT_LSB-1:0];
        if (is_rtype(inst)) begin
            known = funct inside {6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24,
                                  6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
        end else begin
            known = inst[`DP_OP_MSB -: 6] inside {[6'h09:6'h0f]};
        end
        return known && (dest_of(inst) != '0);
    endfunction

    // a slave may pair unless it names the master's destination
    function automatic logic independent(inst_t m, inst_t s);
        return !writes_of(m) || ((rs_of(s) != dest_of(m)) && (rt_of(s) != dest_of(m)));
    endfunction

    function automatic wb_t model_step(inst_t inst);
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      res;
        logic [4:0] sh;
        wb_t        wb;
        a    = model_regs[rs_of(inst)];
        b    = model_regs[rt_of(inst)];
        sh   = inst[`DP_SHAMT_LSB +: 5];
        sext = {{16{inst[15]}}, inst[15:0]};
        zext = {16'h0000, inst[15:0]};
        res  = '0;
        if (is_rtype(inst)) begin
            case (inst[`DP_SHAMT_LSB-1:0])
                6'h00:   res = b << sh;
                6'h02:   res = b >> sh;
                6'h03:   res = word_t'($signed(b) >>> sh);
                6'h21:   res = a + b;
                6'h23:   res = a - b;
                6'h24:   res = a & b;
                6'h25:   res = a | b;
                6'h26:   res = a ^ b;
                6'h27:   res = ~(a | b);
                6'h2a:   res = {31'd0, $signed(a) < $signed(b)};
                6'h2b:   res = {31'd0, a < b};
                default: res = '0;
            endcase
        end else begin
            case (inst[`DP_OP_MSB -: 6])
                6'h09:   res = a + sext;
                6'h0a:   res = {31'd0, $signed(a) < $signed(sext)};
                6'h0b:   res = {31'd0, a < sext};
                6'h0c:   res = a & zext;
                6'h0d:   res = a | zext;
                6'h0e:   res = a ^ zext;
                6'h0f:   res = {inst[15:0], 16'h0000};
                default: res = '0;
            endcase
        end
        wb.valid = writes_of(inst);
        wb.addr  = dest_of(inst);
        wb.data  = res;
        if (wb.valid) begin
            model_regs[wb.addr] = res;
        end
        return wb;
    endfunction

    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = next_rand();
        // mostly r0 to r7 so neighbours collide
        if (r[3:0] != 4'h0) begin
            return {2'b00, r[6:4]};
        end
        return r[8:4];
    endfunction

    function automatic inst_t gen_inst();
        logic [31:0] r;
        logic [31:0] r2;
        int          sel;
        logic [5:0]  code;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        r   = next_rand();
        r2  = next_rand();
        sel = int'(r % 32'd20);
        rs  = pick_reg();
        rt  = pick_reg();
        rd  = pick_reg();
        if ((sel >= 11 && sel <= 17) || sel == 19) begin
            // 6'h3e is an undefined opcode
            code = (sel == 19) ? 6'h3e : 6'h09 + 6'(sel - 11);
            return {code, rs, rt, r2[15:0]};
        end
        case (sel)
            0:       code = 6'h00;
            1:       code = 6'h02;
            2:       code = 6'h03;
            3:       code = 6'h21;
            4:       code = 6'h23;
            5:       code = 6'h24;
            6:       code = 6'h25;
            7:       code = 6'h26;
            8:       code = 6'h27;
            9:       code = 6'h2a;
            10:      code = 6'h2b;
            default: code = 6'h3f;
        endcase
        return {6'h00, rs, rt, rd, r2[4:0], code};
    endfunction

    // addiu r3, r3, imm first, so every pair depends on its master
    function automatic inst_t next_inst(int index);
        logic [31:0] r;
        if (index >= N_CHAIN) begin
            return gen_inst();
        end
        r = next_rand();
        return {6'h09, 5'd3, 5'd3, r[15:0]};
    endfunction

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp, input string lane);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %s wrote r%0d=%h, expected r%0d=%h",
                                      $time, lane, got.addr, got.data, exp.addr, exp.data));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: fetch_stall_o is %b, expected %b",
                                      $time, got, exp));
        end
    endtask

    // non-writing instructions in between retire silently
    task automatic take_report(input wb_t got, input string lane,
                               output inst_t inst, output int skipped);
        wb_t exp;
        exp     = '0;
        inst    = '0;
        skipped = 0;
        while (!exp.valid) begin
            if (expected.size() == 0) begin
                stop_with_error($sformatf("CHECK FAILED at %0t: %s report r%0d with nothing left",
                                          $time, lane, got.addr));
            end
            inst = expected.pop_front();
            exp  = model_step(inst);
            if (!exp.valid) begin
                skipped++;
            end
        end
        check_wb(got, exp, lane);
        report_count++;
    endtask

    always @(posedge clk) begin
        inst_t m_inst;
        inst_t s_inst;
        int    m_skip;
        int    s_skip;
        int    n_pop;
        if (reset_i) begin
            pending.delete();
        end else begin
            check_flag(fetch_stall_o, pending.size() > `DP_FIFO_DEPTH - 2);
            if (wb_master_o.valid) begin
                take_report(wb_master_o, "master", m_inst, m_skip);
            end
            if (wb_slave_o.valid) begin
                take_report(wb_slave_o, "slave", s_inst, s_skip);
                if (wb_master_o.valid && (s_skip != 0 || !independent(m_inst, s_inst))) begin
                    stop_with_error($sformatf("CHECK FAILED at %0t: %s",
                                              $time, "dependent or split pair retired together"));
                end
            end
            // queue occupancy model
            n_pop = 0;
            if (pending.size() > 0) begin
                n_pop = 1;
            end
            if (pending.size() > 1 && independent(pending[0], pending[1])) begin
                n_pop = 2;
            end
            repeat (n_pop) begin
                void'(pending.pop_front());
            end
            if (inst_ok1_i) begin
                pending.push_back(inst1_i);
            end
            if (inst_ok1_i && inst_ok2_i) begin
                pending.push_back(inst2_i);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            stop_with_error($sformatf("timeout after %0d cycles with %0d of %0d reports seen",
                                      cycle_count, report_count, n_writes));
        end
    end

    initial begin : main
        logic [31:0] burst;
        int          sent;
        clk          = 1'b0;
        reset_i      = 1'b1;
        inst1_i      = '0;
        inst2_i      = '0;
        inst_ok1_i   = 1'b0;
        inst_ok2_i   = 1'b0;
        rng          = 32'h4ff8;
        n_writes     = 0;
        report_count = 0;
        sent         = 0;
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(negedge clk);
        reset_i = 1'b0;
        while (sent < N_INST) begin
            inst_ok1_i = 1'b0;
            inst_ok2_i = 1'b0;
            burst      = next_rand();
            // the chain goes in two per cycle and fills the queue
            if (sent < N_CHAIN) begin
                burst[1:0] = 2'b11;
            end
            if (!fetch_stall_o && burst[1:0] != 2'b00) begin
                inst1_i    = next_inst(sent);
                inst_ok1_i = 1'b1;
                expected.push_back(inst1_i);
                n_writes += writes_of(inst1_i) ? 1 : 0;
                sent++;
                if (burst[1] && sent < N_INST) begin
                    inst2_i    = next_inst(sent);
                    inst_ok2_i = 1'b1;
                    expected.push_back(inst2_i);
                    n_writes += writes_of(inst2_i) ? 1 : 0;
                    sent++;
                end
            end
            @(negedge clk);
        end
        inst_ok1_i = 1'b0;
        inst_ok2_i = 1'b0;
        while (report_count < n_writes) begin
            @(negedge clk);
        end
        // room for any stray extra report
        repeat (4) @(negedge clk);
        if (report_count != n_writes) begin
            stop_with_error($sformatf("CHECK FAILED at %0t: %0d reports, expected %0d",
                                      $time, report_count, n_writes));
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath
    import datapath_pkg::*;
(
    input  wire        clk,
    input  wire        reset_i,
    input  wire inst_t inst1_i,
    input  wire inst_t inst2_i,
    input  wire        inst_ok1_i,
    input  wire        inst_ok2_i,
    output logic       fetch_stall_o,
    output wb_t        wb_master_o,
    output wb_t        wb_slave_o
);

    inst_t    head1;
    inst_t    head2;
    logic     empty;
    logic     single;
    logic     issue_m;
    logic     issue_s;
    decoded_t d_dec_m;
    decoded_t d_dec_s;
    word_t    rf_m_rs;
    word_t    rf_m_rt;
    word_t    rf_s_rs;
    word_t    rf_s_rt;
    word_t    d_m_rs;
    word_t    d_m_rt;
    word_t    d_s_rs;
    word_t    d_s_rt;

    decoded_t e_dec_m;
    decoded_t e_dec_s;
    word_t    e_m_rs;
    word_t    e_m_rt;
    word_t    e_s_rs;
    word_t    e_s_rt;
    logic     e_valid_m;
    logic     e_valid_s;
    wb_t      e_res_m;
    wb_t      e_res_s;
    wb_t      w_m;
    wb_t      w_s;

    inst_fifo u_inst_fifo (
        .clk           (clk),
        .reset_i       (reset_i),
        .inst1_i       (inst1_i),
        .inst2_i       (inst2_i),
        .inst_ok1_i    (inst_ok1_i),
        .inst_ok2_i    (inst_ok2_i),
        .pop1_i        (issue_m),
        .pop2_i        (issue_s),
        .head1_o       (head1),
        .head2_o       (head2),
        .empty_o       (empty),
        .single_o      (single),
        .fetch_stall_o (fetch_stall_o)
    );

    decoder u_decoder_master (.inst_i(head1), .dec_o(d_dec_m));
    decoder u_decoder_slave  (.inst_i(head2), .dec_o(d_dec_s));

    issue_ctrl u_issue_ctrl (
        .empty_i        (empty),
        .single_i       (single),
        .master_i       (d_dec_m),
        .slave_i        (d_dec_s),
        .issue_master_o (issue_m),
        .issue_slave_o  (issue_s)
    );

    regfile u_regfile (
        .clk       (clk),
        .reset_i   (reset_i),
        .ra_m_rs_i (d_dec_m.rs),
        .ra_m_rt_i (d_dec_m.rt),
        .ra_s_rs_i (d_dec_s.rs),
        .ra_s_rt_i (d_dec_s.rt),
        .rd_m_rs_o (rf_m_rs),
        .rd_m_rt_o (rf_m_rt),
        .rd_s_rs_o (rf_s_rs),
        .rd_s_rt_o (rf_s_rt),
        .wb_m_i    (w_m),
        .wb_s_i    (w_s)
    );

    forward_top u_forward_top (
        .dec_m_i   (d_dec_m),
        .dec_s_i   (d_dec_s),
        .rf_m_rs_i (rf_m_rs),
        .rf_m_rt_i (rf_m_rt),
        .rf_s_rs_i (rf_s_rs),
        .rf_s_rt_i (rf_s_rt),
        .e_m_i     (e_res_m),
        .e_s_i     (e_res_s),
        .w_m_i     (w_m),
        .w_s_i     (w_s),
        .op_m_rs_o (d_m_rs),
        .op_m_rt_o (d_m_rt),
        .op_s_rs_o (d_s_rs),
        .op_s_rt_o (d_s_rt)
    );

    // D to E, payload always advances
    always_ff @(posedge clk) begin
        e_dec_m <= d_dec_m;
        e_dec_s <= d_dec_s;
        e_m_rs  <= d_m_rs;
        e_m_rt  <= d_m_rt;
        e_s_rs  <= d_s_rs;
        e_s_rt  <= d_s_rt;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            e_valid_m <= 1'b0;
            e_valid_s <= 1'b0;
            w_m       <= '0;
            w_s       <= '0;
        end else begin
            e_valid_m <= issue_m;
            e_valid_s <= issue_s;
            w_m       <= e_res_m;
            w_s       <= e_res_s;
        end
    end

    alu u_alu_master (
        .dec_i    (e_dec_m),
        .valid_i  (e_valid_m),
        .rs_val_i (e_m_rs),
        .rt_val_i (e_m_rt),
        .res_o    (e_res_m)
    );

    alu u_alu_slave (
        .dec_i    (e_dec_s),
        .valid_i  (e_valid_s),
        .rs_val_i (e_s_rs),
        .rt_val_i (e_s_rt),
        .res_o    (e_res_s)
    );

    assign wb_master_o = w_m;
    assign wb_slave_o  = w_s;

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
    import datapath_pkg::*;
(
    input  wire decoded_t dec_i,
    input  wire           valid_i,
    input  wire word_t    rs_val_i,
    input  wire word_t    rt_val_i,
    output wb_t           res_o
);

    word_t src_a;
    word_t src_b;
    word_t result;

    // shifts take the amount from the instruction
    assign src_a = dec_i.use_shamt ? word_t'(dec_i.shamt) : rs_val_i;
    assign src_b = dec_i.use_imm ? dec_i.imm : rt_val_i;

    always_comb begin
        case (dec_i.alu_op)
            ALU_ADDU: result = src_a + src_b;
            ALU_SUBU: result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_NOR:  result = ~(src_a | src_b);
            ALU_SLT:  result = word_t'($signed(src_a) < $signed(src_b));
            ALU_SLTU: result = word_t'(src_a < src_b);
            ALU_SLL:  result = src_b << src_a[4:0];
            ALU_SRL:  result = src_b >> src_a[4:0];
            ALU_SRA:  result = word_t'($signed(src_b) >>> src_a[4:0]);
            ALU_LUI:  result = {src_b[15:0], 16'h0000};
            default:  result = src_a + src_b;
        endcase
    end

    assign res_o.valid = valid_i && dec_i.reg_wen;
    assign res_o.addr  = dec_i.dest;
    assign res_o.data  = result;

endmodule

`default_nettype wire

//--- verilog/forward_top.sv
`timescale 1ns/1ns
`default_nettype none

module forward_top
    import datapath_pkg::*;
(
    input  wire decoded_t dec_m_i,
    input  wire decoded_t dec_s_i,
    input  wire word_t    rf_m_rs_i,
    input  wire word_t    rf_m_rt_i,
    input  wire word_t    rf_s_rs_i,
    input  wire word_t    rf_s_rt_i,
    input  wire wb_t      e_m_i,
    input  wire wb_t      e_s_i,
    input  wire wb_t      w_m_i,
    input  wire wb_t      w_s_i,
    output word_t         op_m_rs_o,
    output word_t         op_m_rt_o,
    output word_t         op_s_rs_o,
    output word_t         op_s_rt_o
);

    function automatic logic hit(wb_t src, reg_addr_t ra);
        return src.valid && (ra != '0) && (src.addr == ra);
    endfunction

    // youngest producer first
    function automatic word_t pick(reg_addr_t ra, word_t rf, wb_t es, wb_t em, wb_t ws, wb_t wm);
        if (hit(es, ra)) begin
            return es.data;
        end else if (hit(em, ra)) begin
            return em.data;
        end else if (hit(ws, ra)) begin
            return ws.data;
        end else if (hit(wm, ra)) begin
            return wm.data;
        end
        return rf;
    endfunction

    assign op_m_rs_o = pick(dec_m_i.rs, rf_m_rs_i, e_s_i, e_m_i, w_s_i, w_m_i);
    assign op_m_rt_o = pick(dec_m_i.rt, rf_m_rt_i, e_s_i, e_m_i, w_s_i, w_m_i);
    assign op_s_rs_o = pick(dec_s_i.rs, rf_s_rs_i, e_s_i, e_m_i, w_s_i, w_m_i);
    assign op_s_rt_o = pick(dec_s_i.rt, rf_s_rt_i, e_s_i, e_m_i, w_s_i, w_m_i);

endmodule

`default_nettype wire

//--- verilog/regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_settings.svh"

module regfile
    import datapath_pkg::*;
(
    input  wire            clk,
    input  wire            reset_i,
    input  wire reg_addr_t ra_m_rs_i,
    input  wire reg_addr_t ra_m_rt_i,
    input  wire reg_addr_t ra_s_rs_i,
    input  wire reg_addr_t ra_s_rt_i,
    output word_t          rd_m_rs_o,
    output word_t          rd_m_rt_o,
    output word_t          rd_s_rs_o,
    output word_t          rd_s_rt_o,
    input  wire wb_t       wb_m_i,
    input  wire wb_t       wb_s_i
);

    word_t regs [1:`DP_NUM_REGS-1];

    // write-through, slave first since it is younger
    function automatic word_t read_port(reg_addr_t ra, word_t stored, wb_t wm, wb_t ws);
        if (ra == '0) begin
            return '0;
        end else if (ws.valid && ws.addr == ra) begin
            return ws.data;
        end else if (wm.valid && wm.addr == ra) begin
            return wm.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < `DP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_m_i.valid && wb_m_i.addr != '0) begin
                regs[wb_m_i.addr] <= wb_m_i.data;
            end
            // slave wins on the same register
            if (wb_s_i.valid && wb_s_i.addr != '0) begin
                regs[wb_s_i.addr] <= wb_s_i.data;
            end
        end
    end

    assign rd_m_rs_o = read_port(ra_m_rs_i, regs[ra_m_rs_i], wb_m_i, wb_s_i);
    assign rd_m_rt_o = read_port(ra_m_rt_i, regs[ra_m_rt_i], wb_m_i, wb_s_i);
    assign rd_s_rs_o = read_port(ra_s_rs_i, regs[ra_s_rs_i], wb_m_i, wb_s_i);
    assign rd_s_rt_o = read_port(ra_s_rt_i, regs[ra_s_rt_i], wb_m_i, wb_s_i);

endmodule

`default_nettype wire

//--- verilog/issue_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module issue_ctrl
    import datapath_pkg::*;
(
    input  wire           empty_i,
    input  wire           single_i,
    input  wire decoded_t master_i,
    input  wire decoded_t slave_i,
    output logic          issue_master_o,
    output logic          issue_slave_o
);

    logic slave_reads_master;

    // slave waits a cycle when it needs the master's result
    assign slave_reads_master = master_i.reg_wen &&
                                ((slave_i.rs == master_i.dest) ||
                                 (slave_i.rt == master_i.dest));

    assign issue_master_o = !empty_i;
    assign issue_slave_o  = issue_master_o && !single_i && !slave_reads_master;

endmodule

`default_nettype wire

//--- verilog/decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_settings.svh"

module decoder
    import datapath_pkg::*;
(
    input  wire inst_t inst_i,
    output decoded_t   dec_o
);

    logic [5:0]  op;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        known;

    assign op    = inst_i[`DP_OP_MSB -: 6];
    assign funct = inst_i[`DP_SHAMT_LSB-1:0];
    assign imm16 = inst_i[`DP_RT_LSB-1:0];

    always_comb begin
        dec_o           = '0;
        dec_o.alu_op    = ALU_ADDU;
        dec_o.rs        = inst_i[`DP_RS_LSB +: $bits(reg_addr_t)];
        dec_o.rt        = inst_i[`DP_RT_LSB +: $bits(reg_addr_t)];
        dec_o.shamt     = inst_i[`DP_SHAMT_LSB +: $bits(shamt_t)];
        known           = 1'b1;
        if (op == 6'h00) begin
            dec_o.dest = inst_i[`DP_RD_LSB +: $bits(reg_addr_t)];
            case (funct)
                6'h00:   dec_o.alu_op = ALU_SLL;
                6'h02:   dec_o.alu_op = ALU_SRL;
                6'h03:   dec_o.alu_op = ALU_SRA;
                6'h21:   dec_o.alu_op = ALU_ADDU;
                6'h23:   dec_o.alu_op = ALU_SUBU;
                6'h24:   dec_o.alu_op = ALU_AND;
                6'h25:   dec_o.alu_op = ALU_OR;
                6'h26:   dec_o.alu_op = ALU_XOR;
                6'h27:   dec_o.alu_op = ALU_NOR;
                6'h2a:   dec_o.alu_op = ALU_SLT;
                6'h2b:   dec_o.alu_op = ALU_SLTU;
                default: known = 1'b0;
            endcase
            dec_o.use_shamt = (funct == 6'h00) || (funct == 6'h02) || (funct == 6'h03);
        end else begin
            // I-type writes rt
            dec_o.dest    = dec_o.rt;
            dec_o.use_imm = 1'b1;
            dec_o.imm     = {16'h0000, imm16};
            case (op)
                6'h09:   dec_o.alu_op = ALU_ADDU;
                6'h0a:   dec_o.alu_op = ALU_SLT;
                6'h0b:   dec_o.alu_op = ALU_SLTU;
                6'h0c:   dec_o.alu_op = ALU_AND;
                6'h0d:   dec_o.alu_op = ALU_OR;
                6'h0e:   dec_o.alu_op = ALU_XOR;
                6'h0f:   dec_o.alu_op = ALU_LUI;
                default: known = 1'b0;
            endcase
            // arithmetic and compares sign-extend
            if (op == 6'h09 || op == 6'h0a || op == 6'h0b) begin
                dec_o.imm = {{16{imm16[15]}}, imm16};
            end
        end
        dec_o.reg_wen = known && (dec_o.dest != '0);
    end

endmodule

`default_nettype wire

//--- verilog/inst_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_settings.svh"

module inst_fifo
    import datapath_pkg::*;
(
    input  wire        clk,
    input  wire        reset_i,
    input  wire inst_t inst1_i,
    input  wire inst_t inst2_i,
    input  wire        inst_ok1_i,
    input  wire        inst_ok2_i,
    input  wire        pop1_i,
    input  wire        pop2_i,
    output inst_t      head1_o,
    output inst_t      head2_o,
    output logic       empty_o,
    output logic       single_o,
    output logic       fetch_stall_o
);

    localparam int AW = $clog2(`DP_FIFO_DEPTH);

    typedef logic [AW-1:0] ptr_t;

    inst_t       mem [`DP_FIFO_DEPTH];
    ptr_t        wptr;
    ptr_t        wptr_nxt;
    ptr_t        rptr;
    ptr_t        rptr_nxt;
    logic [AW:0] count;
    logic [1:0]  n_push;
    logic [1:0]  n_pop;

    assign n_push = {1'b0, inst_ok1_i} + {1'b0, inst_ok1_i & inst_ok2_i};
    assign n_pop  = {1'b0, pop1_i} + {1'b0, pop1_i & pop2_i};

    assign wptr_nxt = wptr + 1'b1;
    assign rptr_nxt = rptr + 1'b1;

    // second word always lands right behind the first
    always_ff @(posedge clk) begin
        if (inst_ok1_i) begin
            mem[wptr] <= inst1_i;
        end
        if (inst_ok1_i && inst_ok2_i) begin
            mem[wptr_nxt] <= inst2_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            wptr  <= wptr + ptr_t'(n_push);
            rptr  <= rptr + ptr_t'(n_pop);
            count <= count + (AW+1)'(n_push) - (AW+1)'(n_pop);
        end
    end

    assign head1_o = mem[rptr];
    assign head2_o = mem[rptr_nxt];

    assign empty_o       = (count == '0);
    assign single_o      = (count == (AW+1)'(1));
    // less than two free slots left
    assign fetch_stall_o = (count > (AW+1)'(`DP_FIFO_DEPTH - 2));

    a_no_write_on_stall: assert property (@(posedge clk) disable iff (reset_i)
        fetch_stall_o |-> !inst_ok1_i && !inst_ok2_i);

    a_pop_in_order: assert property (@(posedge clk) disable iff (reset_i)
        pop2_i |-> pop1_i);

endmodule

`default_nettype wire

//--- verilog/datapath_pkg.sv
`default_nettype none

`include "datapath_settings.svh"

package datapath_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [$clog2(`DP_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [4:0] shamt_t;

    typedef enum logic [3:0] {
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     imm;
        shamt_t    shamt;
        logic      use_imm;
        logic      use_shamt;
        logic      reg_wen;
    } decoded_t;

    // one register write leaving the pipe
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } wb_t;

endpackage

`default_nettype wire

//--- verilog/datapath_settings.svh
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// instruction queue entries, power of two
`define DP_FIFO_DEPTH 8

// architectural registers, r0 reads as zero
`define DP_NUM_REGS 32

// instruction field positions
`define DP_OP_MSB    31
`define DP_RS_LSB    21
`define DP_RT_LSB    16
`define DP_RD_LSB    11
`define DP_SHAMT_LSB 6

`endif
